// File: source/ex_consts.svh
// widths, opcode codes and divider constants for the execute unit, included by package and RTL
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define EX_WORD_W       32
`define EX_DWORD_W      64  // product and hi/lo pair
`define EX_REG_ADDR_W   5
`define EX_OP_W         6

`define EX_OP_OR        6'h01
`define EX_OP_AND       6'h02
`define EX_OP_NOR       6'h03
`define EX_OP_XOR       6'h04
`define EX_OP_SLL       6'h05
`define EX_OP_SRL       6'h06
`define EX_OP_SRA       6'h07
`define EX_OP_ADD       6'h08
`define EX_OP_ADDU      6'h09
`define EX_OP_ADDI      6'h0a
`define EX_OP_ADDIU     6'h0b
`define EX_OP_SUB       6'h0c
`define EX_OP_SUBU      6'h0d
`define EX_OP_SLT       6'h0e
`define EX_OP_SLTU      6'h0f
`define EX_OP_CLZ       6'h10
`define EX_OP_CLO       6'h11
`define EX_OP_MFHI      6'h12
`define EX_OP_MFLO      6'h13
`define EX_OP_MTHI      6'h14
`define EX_OP_MTLO      6'h15
`define EX_OP_MUL       6'h16
`define EX_OP_MULT      6'h17
`define EX_OP_MULTU     6'h18
`define EX_OP_MADD      6'h19
`define EX_OP_MADDU     6'h1a
`define EX_OP_MSUB      6'h1b
`define EX_OP_MSUBU     6'h1c
`define EX_OP_DIV       6'h1d
`define EX_OP_DIVU      6'h1e

`define EX_DIV_STEPS    32  // one quotient bit per step
`define EX_DIV_CNT_W    6

`endif

// File: source/ex_pkg.sv
// shared execute-unit types and the opcode to result-class map, referenced as ex_pkg::name
`default_nettype none
`include "ex_consts.svh"

package ex_pkg;

    typedef logic [`EX_WORD_W-1:0]     word_t;
    typedef logic [`EX_DWORD_W-1:0]    dword_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [`EX_OP_W-1:0] {
        OP_OR    = `EX_OP_OR,    OP_AND   = `EX_OP_AND,   OP_NOR   = `EX_OP_NOR,
        OP_XOR   = `EX_OP_XOR,   OP_SLL   = `EX_OP_SLL,   OP_SRL   = `EX_OP_SRL,
        OP_SRA   = `EX_OP_SRA,   OP_ADD   = `EX_OP_ADD,   OP_ADDU  = `EX_OP_ADDU,
        OP_ADDI  = `EX_OP_ADDI,  OP_ADDIU = `EX_OP_ADDIU, OP_SUB   = `EX_OP_SUB,
        OP_SUBU  = `EX_OP_SUBU,  OP_SLT   = `EX_OP_SLT,   OP_SLTU  = `EX_OP_SLTU,
        OP_CLZ   = `EX_OP_CLZ,   OP_CLO   = `EX_OP_CLO,   OP_MFHI  = `EX_OP_MFHI,
        OP_MFLO  = `EX_OP_MFLO,  OP_MTHI  = `EX_OP_MTHI,  OP_MTLO  = `EX_OP_MTLO,
        OP_MUL   = `EX_OP_MUL,   OP_MULT  = `EX_OP_MULT,  OP_MULTU = `EX_OP_MULTU,
        OP_MADD  = `EX_OP_MADD,  OP_MADDU = `EX_OP_MADDU, OP_MSUB  = `EX_OP_MSUB,
        OP_MSUBU = `EX_OP_MSUBU, OP_DIV   = `EX_OP_DIV,   OP_DIVU  = `EX_OP_DIVU
    } ex_op_e;

    typedef enum logic [2:0] {
        RES_NONE  = 3'd0,  // writes no general register
        RES_LOGIC = 3'd1,
        RES_SHIFT = 3'd2,
        RES_ARITH = 3'd3,
        RES_MOVE  = 3'd4,
        RES_MUL   = 3'd5
    } res_sel_e;

    function automatic res_sel_e res_class(ex_op_e op);
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: return RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        return RES_SHIFT;
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: return RES_ARITH;
            OP_MFHI, OP_MFLO:              return RES_MOVE;
            OP_MUL:                        return RES_MUL;
            default:                       return RES_NONE;  // hi/lo only ops
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/alu_logic_shift.sv
// combinational bitwise logic and barrel shifter of the execute unit
`timescale 1ns/1ps
`default_nettype none

module alu_logic_shift (
    input  wire ex_pkg::ex_op_e op_i,
    input  wire ex_pkg::word_t  src1_i,
    input  wire ex_pkg::word_t  src2_i,
    output ex_pkg::word_t       result_o
);

    logic [4:0] shamt;

    assign shamt = src1_i[4:0];  // shift amount from low bits of src1

    always_comb begin
        case (op_i)
            ex_pkg::OP_OR: begin
                result_o = src1_i | src2_i;
            end
            ex_pkg::OP_AND: begin
                result_o = src1_i & src2_i;
            end
            ex_pkg::OP_NOR: begin
                result_o = ~(src1_i | src2_i);
            end
            ex_pkg::OP_XOR: begin
                result_o = src1_i ^ src2_i;
            end
            ex_pkg::OP_SLL: begin
                result_o = src2_i << shamt;
            end
            ex_pkg::OP_SRL: begin
                result_o = src2_i >> shamt;
            end
            ex_pkg::OP_SRA: begin
                result_o = ex_pkg::word_t'($signed(src2_i) >>> shamt);  // sign fill
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/alu_arith.sv
// combinational add/subtract with overflow, set-less-than and leading zero/one count
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module alu_arith (
    input  wire ex_pkg::ex_op_e op_i,
    input  wire ex_pkg::word_t  src1_i,
    input  wire ex_pkg::word_t  src2_i,
    output ex_pkg::word_t       result_o,
    output logic                overflow_o
);

    localparam int MSB   = `EX_WORD_W - 1;
    localparam int CNT_W = $clog2(`EX_WORD_W + 1);

    logic             sub_op;
    logic             ovf_op;
    ex_pkg::word_t    addend;
    ex_pkg::word_t    sum;
    logic             lt_signed;
    logic [CNT_W-1:0] lead;

    assign sub_op = op_i inside {ex_pkg::OP_SUB, ex_pkg::OP_SUBU, ex_pkg::OP_SLT};
    assign ovf_op = op_i inside {ex_pkg::OP_ADD, ex_pkg::OP_ADDI, ex_pkg::OP_SUB};

    // subtract as src1 + ~src2 + 1 through the one adder
    assign addend = sub_op ? ~src2_i : src2_i;
    assign sum    = src1_i + addend + ex_pkg::word_t'(sub_op);

    assign overflow_o = ovf_op && (src1_i[MSB] == addend[MSB]) && (sum[MSB] != src1_i[MSB]);

    // negative vs positive, or same signs and a negative difference
    assign lt_signed = (src1_i[MSB] && !src2_i[MSB]) ||
                       ((src1_i[MSB] == src2_i[MSB]) && sum[MSB]);

    always_comb begin : lead_count
        ex_pkg::word_t probe;
        logic          hit;
        probe = (op_i == ex_pkg::OP_CLO) ? ~src1_i : src1_i;  // clo counts zeros of inverse
        hit   = 1'b0;
        lead  = CNT_W'(`EX_WORD_W);  // all zero gives full width
        for (int i = MSB; i >= 0; i--) begin
            if (!hit && probe[i]) begin
                lead = CNT_W'(MSB - i);
                hit  = 1'b1;
            end
        end
    end

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU,
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                result_o = sum;
            end
            ex_pkg::OP_SLT: begin
                result_o = ex_pkg::word_t'(lt_signed);
            end
            ex_pkg::OP_SLTU: begin
                result_o = ex_pkg::word_t'(src1_i < src2_i);
            end
            ex_pkg::OP_CLZ, ex_pkg::OP_CLO: begin
                result_o = ex_pkg::word_t'(lead);
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/mul_acc.sv
// signed/unsigned multiplier with the two-cycle multiply-accumulate sequencer for hi/lo
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module mul_acc (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 start_i,
    input  wire ex_pkg::ex_op_e op_i,
    input  wire ex_pkg::word_t  src1_i,
    input  wire ex_pkg::word_t  src2_i,
    input  wire ex_pkg::dword_t hilo_i,
    output ex_pkg::dword_t      product_o,
    output logic                hilo_we_o,
    output ex_pkg::dword_t      hilo_o,
    output logic                busy_o
);

    localparam int MSB = `EX_WORD_W - 1;

    logic           sgn_op;
    logic           mac_op;
    logic           msub_op;
    logic           mult_op;
    logic           neg;
    ex_pkg::word_t  mag1;
    ex_pkg::word_t  mag2;
    ex_pkg::dword_t raw;
    logic           acc_stage;  // second cycle of madd/msub
    ex_pkg::dword_t acc_prod;   // product captured in the first cycle

    assign sgn_op  = op_i inside {ex_pkg::OP_MUL, ex_pkg::OP_MULT,
                                  ex_pkg::OP_MADD, ex_pkg::OP_MSUB};
    assign mac_op  = op_i inside {ex_pkg::OP_MADD, ex_pkg::OP_MADDU,
                                  ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU};
    assign msub_op = op_i inside {ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU};
    assign mult_op = op_i inside {ex_pkg::OP_MULT, ex_pkg::OP_MULTU};

    // unsigned multiply of magnitudes, sign restored afterwards
    assign mag1 = (sgn_op && src1_i[MSB]) ? -src1_i : src1_i;
    assign mag2 = (sgn_op && src2_i[MSB]) ? -src2_i : src2_i;
    assign raw  = mag1 * mag2;
    assign neg  = sgn_op && (src1_i[MSB] ^ src2_i[MSB]);

    assign product_o = neg ? -raw : raw;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            acc_stage <= 1'b0;
        end else begin
            acc_stage <= start_i && mac_op;  // exactly one extra cycle
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && mac_op) begin
            acc_prod <= msub_op ? -product_o : product_o;
        end
    end

    assign busy_o    = acc_stage;
    assign hilo_we_o = acc_stage || (start_i && mult_op);
    assign hilo_o    = acc_stage ? hilo_i + acc_prod : product_o;

    // issue logic holds new work off during the accumulate cycle
    assert property (@(posedge clk) disable iff (rst_i) busy_o |-> !start_i)
        else $error("multiply started during accumulate cycle");

endmodule

`default_nettype wire

// File: source/divider.sv
// radix-2 restoring divider, signed or unsigned, one quotient bit per clock
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module divider (
    input  wire                clk,
    input  wire                rst_i,
    input  wire                start_i,
    input  wire                signed_i,
    input  wire ex_pkg::word_t dividend_i,
    input  wire ex_pkg::word_t divisor_i,
    output logic               done_o,
    output ex_pkg::word_t      quotient_o,
    output ex_pkg::word_t      remainder_o
);

    localparam int MSB = `EX_WORD_W - 1;

    logic                     busy;
    logic [`EX_DIV_CNT_W-1:0] cnt;
    logic                     last;
    ex_pkg::word_t            rem;
    ex_pkg::word_t            quo;   // dividend shifts out as quotient shifts in
    ex_pkg::word_t            dvsr;
    logic                     neg_q;
    logic                     neg_r;
    logic [`EX_WORD_W:0]      trial;
    ex_pkg::word_t            rem_nx;
    ex_pkg::word_t            quo_nx;

    assign trial  = {rem, quo[MSB]} - {1'b0, dvsr};
    assign rem_nx = trial[`EX_WORD_W] ? {rem[MSB-1:0], quo[MSB]} : trial[MSB:0];
    assign quo_nx = {quo[MSB-1:0], !trial[`EX_WORD_W]};  // no borrow sets the bit
    assign last   = (cnt == `EX_DIV_CNT_W'(`EX_DIV_STEPS - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!busy && start_i) begin
                busy   <= (divisor_i != '0);
                done_o <= (divisor_i == '0);  // divide by zero ends at once
                cnt    <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start_i) begin
            rem         <= '0;
            quo         <= (signed_i && dividend_i[MSB]) ? -dividend_i : dividend_i;
            dvsr        <= (signed_i && divisor_i[MSB]) ? -divisor_i : divisor_i;
            neg_q       <= signed_i && (dividend_i[MSB] ^ divisor_i[MSB]);
            neg_r       <= signed_i && dividend_i[MSB];  // remainder follows dividend
            quotient_o  <= '0;
            remainder_o <= '0;
        end else if (busy) begin
            rem <= rem_nx;
            quo <= quo_nx;
            if (last) begin
                quotient_o  <= neg_q ? -quo_nx : quo_nx;
                remainder_o <= neg_r ? -rem_nx : rem_nx;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_i) done_o |=> !done_o)
        else $error("divider done held longer than one cycle");

    // execute unit keeps ready low for the whole division
    assert property (@(posedge clk) disable iff (rst_i) busy |-> !start_i)
        else $error("divide started while a division runs");

endmodule

`default_nettype wire

// File: source/ex_unit.sv
// execute stage top level: issue handshake, hi/lo registers, result select and output register
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module ex_unit (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    valid_i,
    output logic                   ready_o,
    input  wire ex_pkg::ex_op_e    op_i,
    input  wire ex_pkg::word_t     src1_i,
    input  wire ex_pkg::word_t     src2_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    output logic                   valid_o,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output ex_pkg::word_t          wdata_o
);

    ex_pkg::word_t     hi;
    ex_pkg::word_t     lo;
    ex_pkg::word_t     ls_res;
    ex_pkg::word_t     ar_res;
    logic              ar_ovf;
    ex_pkg::dword_t    product;
    logic              hilo_we;
    ex_pkg::dword_t    hilo_new;
    logic              mul_busy;
    logic              div_done;
    ex_pkg::word_t     div_quo;
    ex_pkg::word_t     div_rem;
    logic              div_pend;
    ex_pkg::reg_addr_t pend_wd;    // destination of the multi-cycle op
    ex_pkg::res_sel_e  sel;
    ex_pkg::word_t     res;
    logic              accept;
    logic              is_mac;
    logic              is_div;
    logic              is_mul;
    logic              wreg_eff;

    assign ready_o  = !mul_busy && !div_pend;
    assign accept   = valid_i && ready_o;
    assign sel      = ex_pkg::res_class(op_i);
    assign is_mac   = op_i inside {ex_pkg::OP_MADD, ex_pkg::OP_MADDU,
                                   ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU};
    assign is_div   = op_i inside {ex_pkg::OP_DIV, ex_pkg::OP_DIVU};
    assign is_mul   = is_mac || (op_i inside {ex_pkg::OP_MUL, ex_pkg::OP_MULT, ex_pkg::OP_MULTU});
    assign wreg_eff = wreg_i && !ar_ovf && (sel != ex_pkg::RES_NONE);  // overflow cancels

    alu_logic_shift u_logic_shift (
        .op_i     (op_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .result_o (ls_res)
    );

    alu_arith u_arith (
        .op_i       (op_i),
        .src1_i     (src1_i),
        .src2_i     (src2_i),
        .result_o   (ar_res),
        .overflow_o (ar_ovf)
    );

    mul_acc u_mul_acc (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (accept && is_mul),
        .op_i      (op_i),
        .src1_i    (src1_i),
        .src2_i    (src2_i),
        .hilo_i    ({hi, lo}),
        .product_o (product),
        .hilo_we_o (hilo_we),
        .hilo_o    (hilo_new),
        .busy_o    (mul_busy)
    );

    divider u_divider (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (accept && is_div),
        .signed_i    (op_i == ex_pkg::OP_DIV),
        .dividend_i  (src1_i),
        .divisor_i   (src2_i),
        .done_o      (div_done),
        .quotient_o  (div_quo),
        .remainder_o (div_rem)
    );

    always_comb begin
        case (sel)
            ex_pkg::RES_LOGIC, ex_pkg::RES_SHIFT: res = ls_res;
            ex_pkg::RES_ARITH:                    res = ar_res;
            ex_pkg::RES_MOVE:                     res = (op_i == ex_pkg::OP_MFHI) ? hi : lo;
            ex_pkg::RES_MUL:                      res = product[`EX_WORD_W-1:0];
            default:                              res = '0;
        endcase
    end

    // sources never coincide since multi-cycle ops block issue
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi <= '0;
            lo <= '0;
        end else if (hilo_we) begin
            {hi, lo} <= hilo_new;
        end else if (div_done) begin
            hi <= div_rem;
            lo <= div_quo;
        end else if (accept && op_i == ex_pkg::OP_MTHI) begin
            hi <= src1_i;
        end else if (accept && op_i == ex_pkg::OP_MTLO) begin
            lo <= src1_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_pend <= 1'b0;
        end else if (accept && is_div) begin
            div_pend <= 1'b1;
        end else if (div_done) begin
            div_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_wd <= wd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
        end else if (accept && !is_mac && !is_div) begin
            valid_o <= 1'b1;
            wd_o    <= wd_i;
            wreg_o  <= wreg_eff;
            wdata_o <= res;
        end else if (mul_busy || div_done) begin
            valid_o <= 1'b1;  // multi-cycle ops only update hi/lo
            wd_o    <= pend_wd;
            wreg_o  <= 1'b0;
            wdata_o <= '0;
        end else begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
        end
    end

    // each result traces back to an issue one or two cycles ago, or a running divide
    assert property (@(posedge clk) disable iff (rst_i)
        valid_o |-> $past(accept) || $past(accept, 2) || $past(div_pend))
        else $error("result raised with no accepted operation");

endmodule

`default_nettype wire

// File: test/clk_gen.sv
// free-running testbench clock, instantiated once by the execute unit testbench
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // half period per phase
    end

endmodule

`default_nettype wire

// File: test/ex_unit_tb.sv
// execute unit testbench: issues operations, predicts results and checks every valid_o
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module ex_unit_tb;

    localparam int     OP_BUDGET   = 200;
    localparam int     CYCLE_LIMIT = OP_BUDGET * (`EX_DIV_STEPS + 3) + 3000;  // worst case plus slack
    localparam longint INT_MAX     = 64'sd2147483647;
    localparam longint INT_MIN     = -64'sd2147483648;

    logic              clk;
    logic              rst_i;
    logic              valid_i;
    logic              ready_o;
    ex_pkg::ex_op_e    op_i;
    ex_pkg::word_t     src1_i;
    ex_pkg::word_t     src2_i;
    ex_pkg::reg_addr_t wd_i;
    logic              wreg_i;
    logic              valid_o;
    ex_pkg::reg_addr_t wd_o;
    logic              wreg_o;
    ex_pkg::word_t     wdata_o;

    integer            seed;
    int                cyc = 0;
    int                accept_cyc = 0;
    int                checks = 0;
    int                errors = 0;
    ex_pkg::dword_t    model_hilo;  // hi in the upper word
    ex_pkg::word_t     exp_wdata[$];
    logic              exp_wreg[$];
    ex_pkg::reg_addr_t exp_wd[$];
    int                exp_lat[$];

    ex_pkg::word_t  edge_vals[4] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff};
    ex_pkg::ex_op_e logic_ops[7] = '{ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_NOR,
                                     ex_pkg::OP_XOR, ex_pkg::OP_SLL, ex_pkg::OP_SRL,
                                     ex_pkg::OP_SRA};
    ex_pkg::ex_op_e arith_ops[10] = '{ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_ADDI,
                                      ex_pkg::OP_ADDIU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU,
                                      ex_pkg::OP_SLT, ex_pkg::OP_SLTU, ex_pkg::OP_CLZ,
                                      ex_pkg::OP_CLO};
    ex_pkg::ex_op_e mac_ops[4] = '{ex_pkg::OP_MADD, ex_pkg::OP_MADDU, ex_pkg::OP_MSUB,
                                   ex_pkg::OP_MSUBU};

    clk_gen #(.PERIOD_NS(40.0)) u_clk_gen (.clk_o(clk));

    ex_unit u_ex_unit (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .op_i    (op_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .wd_i    (wd_i),
        .wreg_i  (wreg_i),
        .valid_o (valid_o),
        .wd_o    (wd_o),
        .wreg_o  (wreg_o),
        .wdata_o (wdata_o)
    );

    function automatic ex_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    // expected register result, write flag and hi/lo after one operation
    function automatic void predict_result(
        input  ex_pkg::ex_op_e op,
        input  ex_pkg::word_t  a,
        input  ex_pkg::word_t  b,
        input  ex_pkg::dword_t hilo,
        input  logic           wreg_in,
        output ex_pkg::word_t  wdata,
        output logic           wreg,
        output ex_pkg::dword_t hilo_nx
    );
        longint        wide;
        longint        sp;
        logic [63:0]   up;
        ex_pkg::word_t ma;
        ex_pkg::word_t mb;
        ex_pkg::word_t q;
        ex_pkg::word_t r;
        logic          ovf;
        logic          writes;
        logic          ones;
        logic          stop;
        int            n;
        wdata   = '0;
        ovf     = 1'b0;
        writes  = 1'b1;
        hilo_nx = hilo;
        sp      = longint'($signed(a)) * longint'($signed(b));
        up      = {32'h0, a} * {32'h0, b};
        case (op)
            ex_pkg::OP_OR:  wdata = a | b;
            ex_pkg::OP_AND: wdata = a & b;
            ex_pkg::OP_NOR: wdata = ~(a | b);
            ex_pkg::OP_XOR: wdata = a ^ b;
            ex_pkg::OP_SLL: wdata = b << a[4:0];  // amount from src1
            ex_pkg::OP_SRL: wdata = b >> a[4:0];
            ex_pkg::OP_SRA: wdata = $signed(b) >>> a[4:0];
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU: begin
                wide  = longint'($signed(a)) + longint'($signed(b));
                wdata = a + b;
                ovf   = (op == ex_pkg::OP_ADD || op == ex_pkg::OP_ADDI) &&
                        (wide > INT_MAX || wide < INT_MIN);
            end
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                wide  = longint'($signed(a)) - longint'($signed(b));
                wdata = a - b;
                ovf   = (op == ex_pkg::OP_SUB) && (wide > INT_MAX || wide < INT_MIN);
            end
            ex_pkg::OP_SLT:  wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::OP_SLTU: wdata = (a < b) ? 32'd1 : 32'd0;
            ex_pkg::OP_CLZ, ex_pkg::OP_CLO: begin
                ones = (op == ex_pkg::OP_CLO);
                stop = 1'b0;
                n    = 0;
                for (int i = 31; i >= 0; i--) begin
                    if (!stop && a[i] == ones) n++;
                    else stop = 1'b1;
                end
                wdata = n;
            end
            ex_pkg::OP_MFHI:  wdata = hilo[63:32];
            ex_pkg::OP_MFLO:  wdata = hilo[31:0];
            ex_pkg::OP_MUL:   wdata = sp[31:0];
            ex_pkg::OP_MTHI:  hilo_nx[63:32] = a;
            ex_pkg::OP_MTLO:  hilo_nx[31:0] = a;
            ex_pkg::OP_MULT:  hilo_nx = sp;
            ex_pkg::OP_MULTU: hilo_nx = up;
            ex_pkg::OP_MADD:  hilo_nx = hilo + sp;
            ex_pkg::OP_MADDU: hilo_nx = hilo + up;
            ex_pkg::OP_MSUB:  hilo_nx = hilo - sp;
            ex_pkg::OP_MSUBU: hilo_nx = hilo - up;
            ex_pkg::OP_DIV, ex_pkg::OP_DIVU: begin
                ma = (op == ex_pkg::OP_DIV && a[31]) ? -a : a;
                mb = (op == ex_pkg::OP_DIV && b[31]) ? -b : b;
                q  = (mb == '0) ? '0 : ma / mb;
                r  = (mb == '0) ? '0 : ma % mb;
                if (op == ex_pkg::OP_DIV && (a[31] ^ b[31])) q = -q;  // toward zero
                if (op == ex_pkg::OP_DIV && a[31]) r = -r;  // sign of dividend
                hilo_nx = {r, q};
            end
            default: wdata = '0;
        endcase
        if (!(op inside {ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_NOR, ex_pkg::OP_XOR,
                         ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA, ex_pkg::OP_ADD,
                         ex_pkg::OP_ADDU, ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU, ex_pkg::OP_SUB,
                         ex_pkg::OP_SUBU, ex_pkg::OP_SLT, ex_pkg::OP_SLTU, ex_pkg::OP_CLZ,
                         ex_pkg::OP_CLO, ex_pkg::OP_MFHI, ex_pkg::OP_MFLO, ex_pkg::OP_MUL})) begin
            writes = 1'b0;  // hi/lo only
        end
        wreg = wreg_in && writes && !ovf;
    endfunction

    task automatic issue_op(input ex_pkg::ex_op_e op, input ex_pkg::word_t a,
                            input ex_pkg::word_t b, input logic wr);
        ex_pkg::word_t     e_wdata;
        logic              e_wreg;
        ex_pkg::dword_t    e_hilo;
        ex_pkg::reg_addr_t wd;
        int                lows;
        wd = ex_pkg::reg_addr_t'($random(seed));
        predict_result(op, a, b, model_hilo, wr, e_wdata, e_wreg, e_hilo);
        model_hilo = e_hilo;
        exp_wdata.push_back(e_wdata);
        exp_wreg.push_back(e_wreg);
        exp_wd.push_back(wd);
        if (op inside {ex_pkg::OP_MADD, ex_pkg::OP_MADDU, ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU})
            exp_lat.push_back(2);
        else if (op inside {ex_pkg::OP_DIV, ex_pkg::OP_DIVU})
            exp_lat.push_back((b == '0) ? 2 : `EX_DIV_STEPS + 2);
        else
            exp_lat.push_back(1);
        @(posedge clk);
        #1;
        valid_i = 1'b1;
        op_i    = op;
        src1_i  = a;
        src2_i  = b;
        wd_i    = wd;
        wreg_i  = wr;
        @(negedge clk);
        while (!ready_o) @(negedge clk);
        accept_cyc = cyc;  // taken at the coming edge
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        lows    = 0;
        @(negedge clk);
        while (!valid_o) begin
            if (!ready_o) lows++;
            @(negedge clk);
        end
        if (op inside {ex_pkg::OP_MADD, ex_pkg::OP_MADDU, ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU}) begin
            checks++;
            assert (lows == 1 && ready_o) else begin
                $display("ready_o was not low for exactly one cycle after %s (%0d low)",
                         op.name(), lows);
                errors++;
            end
        end
    endtask

    // divide or multiply, then read back both halves
    task automatic issue_and_read_hilo(input ex_pkg::ex_op_e op, input ex_pkg::word_t a,
                                       input ex_pkg::word_t b);
        issue_op(op, a, b, 1'b1);
        issue_op(ex_pkg::OP_MFHI, '0, '0, 1'b1);
        issue_op(ex_pkg::OP_MFLO, '0, '0, 1'b1);
    endtask

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin : compare
        ex_pkg::word_t     e_wdata;
        logic              e_wreg;
        ex_pkg::reg_addr_t e_wd;
        int                e_lat;
        if (!rst_i && valid_o) begin
            if (exp_wdata.size() == 0) begin
                $display("valid_o raised with no operation outstanding");
                errors++;
            end else begin
                e_wdata = exp_wdata.pop_front();
                e_wreg  = exp_wreg.pop_front();
                e_wd    = exp_wd.pop_front();
                e_lat   = exp_lat.pop_front();
                checks++;
                assert (wdata_o === e_wdata) else begin
                    $display("FAILED wdata_o expected %h actual %h", e_wdata, wdata_o);
                    errors++;
                end
                assert (wreg_o === e_wreg) else begin
                    $display("FAILED wreg_o expected %h actual %h", e_wreg, wreg_o);
                    errors++;
                end
                assert (wd_o === e_wd) else begin
                    $display("FAILED wd_o expected %h actual %h", e_wd, wd_o);
                    errors++;
                end
                assert (cyc - accept_cyc == e_lat) else begin
                    $display("FAILED valid_o latency expected %h actual %h",
                             e_lat, cyc - accept_cyc);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (cyc >= CYCLE_LIMIT);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks %0d, errors %0d", checks, errors);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        seed       = 32'h336f8fdf;
        model_hilo = '0;
        rst_i      = 1'b1;
        valid_i    = 1'b0;
        op_i       = ex_pkg::OP_OR;
        src1_i     = '0;
        src2_i     = '0;
        wd_i       = '0;
        wreg_i     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;
        @(negedge clk);
        checks++;
        assert (valid_o === 1'b0) else begin
            $display("FAILED valid_o expected %h actual %h", 1'b0, valid_o);
            errors++;
        end
        assert (ready_o === 1'b1) else begin
            $display("FAILED ready_o expected %h actual %h", 1'b1, ready_o);
            errors++;
        end
        issue_op(ex_pkg::OP_MFHI, '0, '0, 1'b1);  // hi/lo cleared by reset
        issue_op(ex_pkg::OP_MFLO, '0, '0, 1'b1);
        repeat (24) issue_op(logic_ops[$unsigned($random(seed)) % 7], rand_word(), rand_word(),
                             1'($random(seed)));
        repeat (16) issue_op(arith_ops[$unsigned($random(seed)) % 10], rand_word(), rand_word(),
                             1'b1);
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                issue_op(ex_pkg::OP_ADD, edge_vals[i], edge_vals[j], 1'b1);
                issue_op(ex_pkg::OP_ADDI, edge_vals[i], edge_vals[j], 1'b1);
                issue_op(ex_pkg::OP_SUB, edge_vals[i], edge_vals[j], 1'b1);
                issue_op(ex_pkg::OP_SLT, edge_vals[i], edge_vals[j], 1'b1);
                issue_op(ex_pkg::OP_SLTU, edge_vals[i], edge_vals[j], 1'b1);
            end
            issue_op(ex_pkg::OP_CLZ, edge_vals[i], '0, 1'b1);
            issue_op(ex_pkg::OP_CLO, edge_vals[i], '0, 1'b1);
        end
        repeat (4) issue_op(ex_pkg::OP_MUL, rand_word(), rand_word(), 1'b1);
        repeat (3) issue_and_read_hilo(ex_pkg::OP_MULT, rand_word(), rand_word());
        repeat (3) issue_and_read_hilo(ex_pkg::OP_MULTU, rand_word(), rand_word());
        for (int k = 0; k < 4; k++) begin
            issue_op(ex_pkg::OP_MTHI, rand_word(), '0, 1'b1);
            issue_op(ex_pkg::OP_MTLO, rand_word(), '0, 1'b1);
            issue_and_read_hilo(mac_ops[k], rand_word(), rand_word());
        end
        repeat (2) issue_and_read_hilo(ex_pkg::OP_DIV, rand_word(), rand_word());
        repeat (2) issue_and_read_hilo(ex_pkg::OP_DIVU, rand_word(), rand_word() >> 8);
        issue_and_read_hilo(ex_pkg::OP_DIV, -32'sd7, 32'd2);
        issue_and_read_hilo(ex_pkg::OP_DIV, 32'd7, -32'sd2);
        issue_and_read_hilo(ex_pkg::OP_DIV, -32'sd7, -32'sd2);
        issue_and_read_hilo(ex_pkg::OP_DIVU, 32'hfffffff9, 32'd2);
        issue_and_read_hilo(ex_pkg::OP_DIV, 32'h80000000, 32'hffffffff);
        issue_and_read_hilo(ex_pkg::OP_DIV, rand_word(), '0);  // zero divisor
        issue_and_read_hilo(ex_pkg::OP_DIVU, rand_word(), '0);
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/ex_pkg.sv
source/alu_logic_shift.sv
source/alu_arith.sv
source/mul_acc.sv
source/divider.sv
source/ex_unit.sv
test/clk_gen.sv
test/ex_unit_tb.sv
